/* vlog.f */
dcache_pkg.sv
dcache_tag_ram.sv
dcache_data_ram.sv
dcache_way_select.sv
dcache_ctrl.sv
dcache_top.sv
dcache_props.sv
dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module dcache_tb -f vlog.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log
if grep -q "^TB PASSED$" sim.log; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi

/* dcache_tb.sv */
// Data cache testbench with directed tests against a memory model and a shadow copy
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
;

    localparam int CLK_PERIOD  = 40;
    localparam int IDX_W       = 6;
    localparam int REQ_TIMEOUT = 40;
    // about 220 requests of at most 30 cycles each
    localparam int WATCHDOG_NS = (220 * 30 + 100) * CLK_PERIOD;
    localparam word_t FILL_KEY = 64'hA5A5_0000_5A5A_0000;

    logic     clk;
    logic     rst_n_i;
    cpu_req_t req_i;
    logic     req_valid_i;
    logic     req_ready_o;
    logic     resp_valid_o;
    word_t    resp_rdata_o;
    mem_req_t mem_req_o;
    logic     mem_req_valid_o;
    logic     mem_req_ready_i;
    logic     mem_resp_valid_i;
    word_t    mem_rdata_i;

    word_t mem_words [line_addr_t];
    word_t shadow [line_addr_t];
    int    rd_count;
    int    wr_count;
    addr_t last_wr_addr;
    word_t last_wr_data;
    int    errors;
    int    checks;
    int    tests_run;

    dcache_top #(
        .NUM_SETS (64)
    ) dcache_top_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_i            (req_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .mem_req_o        (mem_req_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_rdata_i      (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    function automatic word_t default_word(input line_addr_t line);
        return {3'b000, line} ^ FILL_KEY;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set);
        return (addr_t'(tag) << (IDX_W + OFFSET_W)) | (addr_t'(set) << OFFSET_W);
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        line_addr_t line;
        line = addr[63:OFFSET_W];
        return shadow.exists(line) ? shadow[line] : default_word(line);
    endfunction

    // memory model accepting after 0 to 3 cycles and answering a read one cycle later
    initial begin
        line_addr_t line;
        mem_req_t   req;
        int         delay;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_rdata_i      = '0;
        rd_count         = 0;
        wr_count         = 0;
        forever begin
            @(negedge clk);
            if (rst_n_i && mem_req_valid_o) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                req  = mem_req_o;
                line = req.addr[63:OFFSET_W];
                @(posedge clk);
                #2 mem_req_ready_i = 1'b1;
                @(posedge clk);
                #2 mem_req_ready_i = 1'b0;
                if (req.write) begin
                    mem_words[line] = req.wdata;
                    last_wr_addr    = req.addr;
                    last_wr_data    = req.wdata;
                    wr_count++;
                end else begin
                    rd_count++;
                    mem_resp_valid_i = 1'b1;
                    mem_rdata_i = mem_words.exists(line) ? mem_words[line] : default_word(line);
                    @(posedge clk);
                    #2 mem_resp_valid_i = 1'b0;
                end
            end
        end
    end

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        assert (exp == act) else begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // one request with lat counting cycles from acceptance to the response
    task automatic access(input addr_t addr, input word_t wdata, input strb_t wstrb,
                          input logic write, output word_t rdata, output int lat);
        @(posedge clk);
        #2;
        req_i       = '{addr: addr, wdata: wdata, wstrb: wstrb, write: write};
        req_valid_i = 1'b1;
        @(negedge clk);
        while (!req_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2 req_valid_i = 1'b0;
        lat   = 0;
        rdata = '0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid_o && lat < REQ_TIMEOUT);
        if (resp_valid_o) begin
            rdata = resp_rdata_o;
        end else begin
            $display("request to %h got no response within %0d cycles", addr, REQ_TIMEOUT);
            errors++;
        end
    endtask

    task automatic write_word(input addr_t addr, input word_t wdata, input strb_t wstrb);
        word_t rdata;
        int    lat;
        shadow[addr[63:OFFSET_W]] = merge_bytes(expected_word(addr), wdata, wstrb);
        access(addr, wdata, wstrb, 1'b1, rdata, lat);
    endtask

    task automatic read_check(input string name, input addr_t addr, output int lat);
        word_t rdata;
        access(addr, '0, '0, 1'b0, rdata, lat);
        check_value(name, expected_word(addr), rdata);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_count("reset req_ready_o", 1, int'(req_ready_o));
        check_count("reset resp_valid_o", 0, int'(resp_valid_o));
        check_count("reset mem_req_valid_o", 0, int'(mem_req_valid_o));
        finish_test("reset", e0);
    endtask

    task automatic test_read_miss_hit();
        int e0;
        int rd0;
        int wr0;
        int lat;
        e0  = errors;
        rd0 = rd_count;
        wr0 = wr_count;
        read_check("read_miss data", make_addr(3, 5), lat);
        check_count("read_miss refills", rd0 + 1, rd_count);
        check_count("read_miss writebacks", wr0, wr_count);
        read_check("read_hit data", make_addr(3, 5), lat);
        check_count("read_hit latency", 2, lat);
        check_count("read_hit memory reads", rd0 + 1, rd_count);
        finish_test("read_miss_hit", e0);
    endtask

    task automatic test_write_strobes();
        int e0;
        int rd0;
        int lat;
        e0 = errors;
        read_check("write_hit preload", make_addr(2, 7), lat);
        write_word(make_addr(2, 7), 64'h1122_3344_5566_7788, 8'h0F);
        read_check("write_hit merge", make_addr(2, 7), lat);
        rd0 = rd_count;
        write_word(make_addr(4, 8), 64'hCAFE_F00D_DEAD_BEEF, 8'hF0);
        check_count("write_miss refills", rd0 + 1, rd_count);
        read_check("write_miss merge", make_addr(4, 8), lat);
        finish_test("write_strobes", e0);
    endtask

    task automatic test_dirty_evict();
        int e0;
        int rd0;
        int wr0;
        int lat;
        e0 = errors;
        write_word(make_addr(1, 10), 64'h0123_4567_89AB_CDEF, 8'h3C);
        read_check("evict read b", make_addr(2, 10), lat);
        wr0 = wr_count;
        read_check("evict read c", make_addr(3, 10), lat);
        check_count("evict writebacks", wr0 + 1, wr_count);
        check_value("evict writeback addr", make_addr(1, 10), last_wr_addr);
        check_value("evict writeback data", expected_word(make_addr(1, 10)), last_wr_data);
        rd0 = rd_count;
        read_check("evict reread a", make_addr(1, 10), lat);
        check_count("evict reread refills", rd0 + 1, rd_count);
        finish_test("dirty_evict", e0);
    endtask

    task automatic test_lru_order();
        int e0;
        int rd0;
        int lat;
        e0 = errors;
        read_check("lru read a", make_addr(1, 20), lat);
        read_check("lru read b", make_addr(2, 20), lat);
        read_check("lru touch a", make_addr(1, 20), lat);
        read_check("lru read c", make_addr(3, 20), lat);
        rd0 = rd_count;
        read_check("lru a resident", make_addr(1, 20), lat);
        check_count("lru a latency", 2, lat);
        check_count("lru a memory reads", rd0, rd_count);
        read_check("lru b evicted", make_addr(2, 20), lat);
        check_count("lru b refills", rd0 + 1, rd_count);
        finish_test("lru_order", e0);
    endtask

    task automatic test_random_mix();
        int    e0;
        int    lat;
        addr_t addr;
        e0 = errors;
        for (int i = 0; i < 200; i++) begin
            addr = make_addr($urandom_range(6, 1), 40 + $urandom_range(3, 0));
            if ($urandom_range(1, 0) == 1) begin
                write_word(addr, {$urandom, $urandom}, strb_t'($urandom_range(255, 1)));
            end else begin
                read_check("random read", addr, lat);
            end
        end
        finish_test("random_mix", e0);
    endtask

    initial begin
        void'($urandom(23005));
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (5) @(posedge clk);
        #2 rst_n_i = 1'b1;
        test_reset();
        test_read_miss_hit();
        test_write_strobes();
        test_dirty_evict();
        test_lru_order();
        test_random_mix();
        // handshake property failures count as errors too
        errors += dcache_top_inst.dcache_props_inst.fail_count;
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_props.sv */
// Handshake properties of the data cache bound into the top level
`timescale 1ns/1ps
`default_nettype none

module dcache_props
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     rst_n_i,
    input logic     req_ready_o,
    input logic     resp_valid_o,
    input mem_req_t mem_req_o,
    input logic     mem_req_valid_o,
    input logic     mem_req_ready_i
);

    int fail_count = 0;

    // payload held while memory stalls
    mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
        else begin
            $error("memory request changed while waiting for ready");
            fail_count++;
        end

    resp_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(resp_valid_o && req_ready_o))
        else begin
            $error("response and request ready high in the same cycle");
            fail_count++;
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
        resp_valid_o |=> !resp_valid_o)
        else begin
            $error("response valid held longer than one cycle");
            fail_count++;
        end

    mem_idle_in_reset: assert property (@(posedge clk) !rst_n_i |=> !mem_req_valid_o)
        else begin
            $error("memory request valid after a reset edge");
            fail_count++;
        end

endmodule

bind dcache_top dcache_props dcache_props_inst (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i)
);

`default_nettype wire

/* dcache_top.sv */
// Data cache top: controller, way selection and the per-way tag and data RAMs
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  cpu_req_t req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    output logic     resp_valid_o,
    output word_t    resp_rdata_o,
    output mem_req_t mem_req_o,
    output logic     mem_req_valid_o,
    input  logic     mem_req_ready_i,
    input  logic     mem_resp_valid_i,
    input  word_t    mem_rdata_i
);

    localparam int IDX_W = $clog2(NUM_SETS);

    logic [IDX_W-1:0]          index;
    line_addr_t                req_line;
    logic [NUM_WAYS-1:0]       tag_we;
    logic [NUM_WAYS-1:0]       tag_valid;
    line_addr_t [NUM_WAYS-1:0] tag_line;
    word_t [NUM_WAYS-1:0]      rdata;
    strb_t [NUM_WAYS-1:0]      data_wstrb;
    word_t [NUM_WAYS-1:0]      data_wdata;
    logic                      hit;
    way_t                      hit_way;
    way_t                      victim_way;
    logic                      victim_dirty;
    line_addr_t                victim_line;
    logic                      touch;
    way_t                      touch_way;
    logic                      write_hit;
    logic                      fill;
    way_t                      fill_way;

    dcache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) dcache_ctrl_inst (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .req_i            (req_i),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .mem_req_o        (mem_req_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_rdata_i      (mem_rdata_i),
        .index_o          (index),
        .req_line_o       (req_line),
        .rdata_i          (rdata),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty),
        .victim_line_i    (victim_line),
        .data_wstrb_o     (data_wstrb),
        .data_wdata_o     (data_wdata),
        .tag_we_o         (tag_we),
        .touch_o          (touch),
        .touch_way_o      (touch_way),
        .write_hit_o      (write_hit),
        .fill_o           (fill),
        .fill_way_o       (fill_way)
    );

    dcache_way_select #(
        .NUM_SETS (NUM_SETS)
    ) dcache_way_select_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .index_i        (index),
        .req_line_i     (req_line),
        .tag_valid_i    (tag_valid),
        .tag_line_i     (tag_line),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .write_hit_i    (write_hit),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_line_o  (victim_line)
    );

    // one tag RAM and one data RAM per way
    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        dcache_tag_ram #(
            .NUM_SETS (NUM_SETS)
        ) dcache_tag_ram_inst (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .index_i (index),
            .we_i    (tag_we[w]),
            .line_i  (req_line),
            .valid_o (tag_valid[w]),
            .line_o  (tag_line[w])
        );

        dcache_data_ram #(
            .NUM_SETS (NUM_SETS)
        ) dcache_data_ram_inst (
            .clk     (clk),
            .index_i (index),
            .wstrb_i (data_wstrb[w]),
            .wdata_i (data_wdata[w]),
            .rdata_o (rdata[w])
        );
    end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
// Cache controller: request FSM for lookup, hit, write-back and refill
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  cpu_req_t                      req_i,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    output logic                          resp_valid_o,
    output word_t                         resp_rdata_o,
    output mem_req_t                      mem_req_o,
    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_resp_valid_i,
    input  word_t                         mem_rdata_i,
    output logic [$clog2(NUM_SETS)-1:0]   index_o,
    output line_addr_t                    req_line_o,
    input  word_t [NUM_WAYS-1:0]          rdata_i,
    input  logic                          hit_i,
    input  way_t                          hit_way_i,
    input  way_t                          victim_way_i,
    input  logic                          victim_dirty_i,
    input  line_addr_t                    victim_line_i,
    output strb_t [NUM_WAYS-1:0]          data_wstrb_o,
    output word_t [NUM_WAYS-1:0]          data_wdata_o,
    output logic [NUM_WAYS-1:0]           tag_we_o,
    output logic                          touch_o,
    output way_t                          touch_way_o,
    output logic                          write_hit_o,
    output logic                          fill_o,
    output way_t                          fill_way_o
);

    localparam int IDX_W = $clog2(NUM_SETS);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    cpu_req_t    req_q;
    mem_req_t    mem_req_q;
    mem_req_t    refill_req;
    way_t        victim_way_q;
    word_t       wdata_sel;

    assign req_line_o = req_q.addr[63:OFFSET_W];
    assign index_o    = req_q.addr[OFFSET_W +: IDX_W];

    assign refill_req = '{addr: {req_line_o, {OFFSET_W{1'b0}}}, wdata: '0, write: 1'b0};

    // refill data while waiting on memory, core data otherwise
    assign wdata_sel    = (state_q == REFILL_WAIT) ? mem_rdata_i : req_q.wdata;
    assign data_wdata_o = {NUM_WAYS{wdata_sel}};
    assign resp_rdata_o = rdata_i[hit_way_i];
    assign mem_req_o    = mem_req_q;

    always_comb begin
        state_d         = state_q;
        req_ready_o     = 1'b0;
        resp_valid_o    = 1'b0;
        mem_req_valid_o = 1'b0;
        data_wstrb_o    = '0;
        tag_we_o        = '0;
        touch_o         = 1'b0;
        touch_way_o     = hit_way_i;
        write_hit_o     = 1'b0;
        fill_o          = 1'b0;
        fill_way_o      = victim_way_q;
        case (state_q)
            IDLE: begin
                req_ready_o = 1'b1;
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = COMPARE;
            end
            COMPARE: begin
                if (hit_i) begin
                    resp_valid_o = 1'b1;
                    touch_o      = 1'b1;
                    if (req_q.write) begin
                        data_wstrb_o[hit_way_i] = req_q.wstrb;
                        write_hit_o             = 1'b1;
                    end
                    state_d = IDLE;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_resp_valid_i) begin
                    data_wstrb_o[victim_way_q] = '1;
                    tag_we_o[victim_way_q]     = 1'b1;
                    fill_o                     = 1'b1;
                    // replay so a write miss merges on the hit path
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request, victim and memory payload registers
    always_ff @(posedge clk) begin
        if (req_ready_o && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == COMPARE && !hit_i) begin
            victim_way_q <= victim_way_i;
            if (victim_dirty_i) begin
                mem_req_q.addr  <= {victim_line_i, {OFFSET_W{1'b0}}};
                mem_req_q.wdata <= rdata_i[victim_way_i];
                mem_req_q.write <= 1'b1;
            end else begin
                mem_req_q <= refill_req;
            end
        end else if (state_q == WRITEBACK && mem_req_ready_i) begin
            mem_req_q <= refill_req;
        end
    end

endmodule

`default_nettype wire

/* dcache_way_select.sv */
// Way selection: tag compare, per-set LRU and dirty state, victim choice
`timescale 1ns/1ps
`default_nettype none

module dcache_way_select
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [$clog2(NUM_SETS)-1:0]   index_i,
    input  line_addr_t                    req_line_i,
    input  logic [NUM_WAYS-1:0]           tag_valid_i,
    input  line_addr_t [NUM_WAYS-1:0]     tag_line_i,
    input  logic                          touch_i,
    input  way_t                          touch_way_i,
    input  logic                          write_hit_i,
    input  logic                          fill_i,
    input  way_t                          fill_way_i,
    output logic                          hit_o,
    output way_t                          hit_way_o,
    output way_t                          victim_way_o,
    output logic                          victim_dirty_o,
    output line_addr_t                    victim_line_o
);

    // lru_q names the least recently used way of each set
    logic [NUM_SETS-1:0]                lru_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0]  dirty_q;
    logic [NUM_WAYS-1:0]                match;
    way_t                               victim;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = tag_valid_i[w] && (tag_line_i[w] == req_line_i);
        end
    end

    assign hit_o     = |match;
    assign hit_way_o = way_t'(match[1]);

    // empty way first, way 0 before way 1
    always_comb begin
        if (!tag_valid_i[0]) begin
            victim = way_t'(0);
        end else if (!tag_valid_i[1]) begin
            victim = way_t'(1);
        end else begin
            victim = way_t'(lru_q[index_i]);
        end
    end

    assign victim_way_o   = victim;
    assign victim_dirty_o = dirty_q[victim][index_i];
    assign victim_line_o  = tag_line_i[victim];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else begin
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end else if (fill_i) begin
                lru_q[index_i] <= ~fill_way_i;
            end
            if (write_hit_i) begin
                dirty_q[touch_way_i][index_i] <= 1'b1;
            end
            // a fresh line from memory is clean
            if (fill_i) begin
                dirty_q[fill_way_i][index_i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_data_ram.sv */
// Data RAM: one word per set with byte-lane writes and a registered read
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                        clk,
    input  logic [$clog2(NUM_SETS)-1:0] index_i,
    input  strb_t                       wstrb_i,
    input  word_t                       wdata_i,
    output word_t                       rdata_o
);

    word_t mem [NUM_SETS];

    // each enabled lane is written on its own
    always_ff @(posedge clk) begin
        for (int b = 0; b < 8; b++) begin
            if (wstrb_i[b]) begin
                mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        rdata_o <= mem[index_i];
    end

endmodule

`default_nettype wire

/* dcache_tag_ram.sv */
// Tag RAM: one valid bit and one line address per set, synchronous read
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_ram
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [$clog2(NUM_SETS)-1:0] index_i,
    input  logic                        we_i,
    input  line_addr_t                  line_i,
    output logic                        valid_o,
    output line_addr_t                  line_o
);

    logic [NUM_SETS-1:0] valid_q;
    line_addr_t          lines [NUM_SETS];

    // valid bits and registered valid output
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_q[index_i];
            if (we_i) begin
                valid_q[index_i] <= 1'b1;
            end
        end
    end

    // line address storage, read before write
    always_ff @(posedge clk) begin
        line_o <= lines[index_i];
        if (we_i) begin
            lines[index_i] <= line_i;
        end
    end

endmodule

`default_nettype wire

/* dcache_pkg.sv */
// Data cache package: shared address, data and request types for the two-way cache
`default_nettype none

package dcache_pkg;

    // byte address and word-granular line address
    typedef logic [63:0] addr_t;
    typedef logic [60:0] line_addr_t;

    typedef logic [63:0] word_t;
    typedef logic [7:0]  strb_t;
    typedef logic [0:0]  way_t;

    localparam int NUM_WAYS = 2;
    localparam int OFFSET_W = 3;

    // request from the core
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  write;
    } cpu_req_t;

    // request to memory, always word aligned
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT
    } ctrl_state_e;

endpackage

`default_nettype wire
